// ==== testbench/simd_alu_trace.txt ====
# columns in hex: oper lane_size signedness a b expected_result
# oper 0 add 1 sub 2 slt 3 and 4 or 5 xor 6 shl 7 shr 8 inv 9 not, size 0..3 is 8..64 bits
0 0 0 ffffffffffffffff 0101010101010101 0000000000000000
0 1 0 00ff00ff00ff00ff 0001000100010001 0100010001000100
0 1 0 ffffffffffffffff 0001000100010001 0000000000000000
0 2 0 7fffffffffffffff 0000000100000001 8000000000000000
0 3 0 00000000ffffffff 0000000000000001 0000000100000000
0 3 0 ffffffffffffffff 0000000000000001 0000000000000000
0 0 0 0102030405060708 1010101010101010 1112131415161718
1 0 0 0000000000000000 0101010101010101 ffffffffffffffff
1 1 0 0000000000000000 0001000100010001 ffffffffffffffff
1 2 0 0000000100000000 0000000000000001 00000001ffffffff
1 3 0 0000000100000000 0000000000000001 00000000ffffffff
1 1 0 1234567890abcdef 0234013500010fef 1000554390aabe00
2 0 0 80017f00ff020304 01807f01fe030203 0001000100010000
2 0 1 80017f00ff020304 01807f01fe030203 0100000100010000
2 1 0 8000000012340001 0000800012350001 0000000100010000
2 1 1 8000000012340001 0000800012350001 0001000000010000
2 2 0 80000000fffffffe 00000000ffffffff 0000000000000001
2 2 1 80000000fffffffe 00000000ffffffff 0000000100000001
2 3 0 8000000000000000 0000000000000000 0000000000000000
2 3 1 8000000000000000 0000000000000000 0000000000000001
3 0 0 ff00f0f0aaaa5555 0f0fff00ffff0f0f 0f00f000aaaa0505
4 1 0 ff00f0f0aaaa5555 0f0fff00ffff0f0f ff0ffff0ffff5f5f
5 2 0 ff00f0f0aaaa5555 0f0fff00ffff0f0f f00f0ff055555a5a
8 3 0 ff00f0f0aaaa5555 0000000000000000 00ff0f0f5555aaaa
9 0 0 0001000200ff0000 0000000000000000 0100010001000101
9 1 0 0001000200ff0000 0000000000000000 0000000000000001
9 2 0 0000000000010000 0000000000000000 0000000100000000
9 3 0 0000000000000000 0000000000000000 0000000000000001
c 0 0 ffffffffffffffff ffffffffffffffff 0000000000000000
6 0 0 ffffffffffffffff 0001070809ff0302 fffe80000000f8fc
7 0 0 80ff7f0180ff7f01 0001070800010708 807f0000807f0000
7 0 1 80ff7f0180ff7f01 0001070800010708 80ff000080ff0000
7 1 0 8000800080008000 0000000f00100001 8000000100004000
7 1 1 8000800080008000 0000000f00100001 8000ffffffffc000
6 2 0 0000000100000001 0000001f00000020 8000000000000000
7 2 1 f000000012345678 0000000400000020 ff00000000000000
6 3 0 0000000000000001 000000000000003f 8000000000000000
7 3 0 8000000000000000 0000000000000040 0000000000000000
7 3 1 8000000000000000 000000000000003f ffffffffffffffff

// ==== project.f ====
+incdir+verilog
verilog/simd_alu_pkg.sv
verilog/alu_lane.sv
verilog/lane_array.sv
verilog/lane_shifter.sv
verilog/result_stage.sv
verilog/simd_alu.sv
testbench/simd_alu_checker.sv
testbench/simd_alu_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the SIMD ALU testbench with Verilator

log_file=sim.log
build_dir=obj_dir

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
	echo "cannot change to the project directory"
	exit 1
fi

verilator --binary --timing --assert -f project.f --top-module simd_alu_tb \
	--Mdir "$build_dir" -o simd_alu_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

"./$build_dir/simd_alu_sim" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if grep -q "Checks failed" "$log_file"; then
	echo "result: FAIL"
	exit 1
fi
echo "result: PASS"
exit 0

// ==== testbench/simd_alu_tb.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "simd_alu_consts.svh"

module simd_alu_tb
	import simd_alu_pkg::*;
();

	localparam int clk_period = 8;
	localparam int reset_cycles = 5;
	localparam int tail_cycles = 3;

	logic clk = 1'b0;
	logic rst_n;
	logic op_valid;
	logic [`SIMD_DATA_WIDTH-1:0] a;
	logic [`SIMD_DATA_WIDTH-1:0] b;
	alu_op_e oper;
	lane_size_e lane_size;
	logic signedness;
	logic [`SIMD_DATA_WIDTH-1:0] result;
	logic result_valid;

	// trace contents with one entry per operation
	logic [3:0] t_oper [$];
	logic [1:0] t_size [$];
	logic t_sgn [$];
	logic [`SIMD_DATA_WIDTH-1:0] t_a [$];
	logic [`SIMD_DATA_WIDTH-1:0] t_b [$];
	logic [`SIMD_DATA_WIDTH-1:0] t_exp [$];

	// operations issued but not yet checked
	int pending [$];

	int n_tests = 0;
	int passed = 0;
	int errors = 0;
	int run_cycles = 0;
	logic trace_loaded = 1'b0;
	logic valid_prev = 1'b0;
	logic [`SIMD_DATA_WIDTH-1:0] last_result = '0;

	simd_alu i_simd_alu (
		.clk(clk),
		.rst_n(rst_n),
		.op_valid(op_valid),
		.a(a),
		.b(b),
		.oper(oper),
		.lane_size(lane_size),
		.signedness(signedness),
		.result(result),
		.result_valid(result_valid)
	);

	always #(clk_period / 2) clk = ~clk;

	// idle cycles ahead of every fourth operation
	function automatic int gap_before(input int idx);
		if (idx > 0 && idx % 4 == 0)
		begin
			return (idx / 4) % 3 + 1;
		end
		return 0;
	endfunction

	task automatic load_trace();
		int fd;
		int count;
		string line;
		logic [3:0] f_oper;
		logic [1:0] f_size;
		logic f_sgn;
		logic [`SIMD_DATA_WIDTH-1:0] f_a;
		logic [`SIMD_DATA_WIDTH-1:0] f_b;
		logic [`SIMD_DATA_WIDTH-1:0] f_exp;
		fd = $fopen("testbench/simd_alu_trace.txt", "r");
		if (fd == 0)
		begin
			$display("cannot open testbench/simd_alu_trace.txt");
		end
		else
		begin
			while (!$feof(fd))
			begin
				if ($fgets(line, fd) > 0)
				begin
					// comment lines do not scan as six fields
					count = $sscanf(line, "%h %h %h %h %h %h",
						f_oper, f_size, f_sgn, f_a, f_b, f_exp);
					if (count == 6)
					begin
						t_oper.push_back(f_oper);
						t_size.push_back(f_size);
						t_sgn.push_back(f_sgn);
						t_a.push_back(f_a);
						t_b.push_back(f_b);
						t_exp.push_back(f_exp);
					end
				end
			end
			$fclose(fd);
		end
	endtask

	task automatic issue_op(input int idx);
		@(posedge clk);
		op_valid <= 1'b1;
		oper <= alu_op_e'(t_oper[idx]);
		lane_size <= lane_size_e'(t_size[idx]);
		signedness <= t_sgn[idx];
		a <= t_a[idx];
		b <= t_b[idx];
		pending.push_back(idx);
	endtask

	task automatic idle_cycles(input int count);
		repeat (count)
		begin
			@(posedge clk);
			op_valid <= 1'b0;
			// change operands so a held result differs from a fresh one
			oper <= op_inv;
			a <= ~a;
		end
	endtask

	task automatic check_outputs();
		int idx;
		logic ok;
		logic [`SIMD_DATA_WIDTH-1:0] expected;
		assert (result_valid === valid_prev)
		else
		begin
			$display("ERR %0t result_valid expected %b actual %b",
				$time, valid_prev, result_valid);
			errors++;
		end
		if (result_valid === 1'b1)
		begin
			assert (pending.size() != 0)
			else
			begin
				$display("result_valid was high at %0t with no operation issued", $time);
				errors++;
			end
			if (pending.size() != 0)
			begin
				idx = pending.pop_front();
				expected = t_exp[idx];
				ok = 1'b1;
				n_tests++;
				assert (result === expected)
				else
				begin
					$display("ERR %0t result expected %h actual %h", $time, expected, result);
					ok = 1'b0;
					errors++;
				end
				if (ok)
				begin
					passed++;
				end
				$display("test %0d oper %0d size %0d signed %0d: %s", idx, t_oper[idx],
					t_size[idx], t_sgn[idx], ok ? "ok" : "wrong result");
			end
		end
		else
		begin
			assert (result === last_result)
			else
			begin
				$display("ERR %0t result expected %h actual %h", $time, last_result, result);
				errors++;
			end
		end
		last_result = result;
	endtask

	// outputs are stable at the falling edge
	always @(negedge clk)
	begin
		if (rst_n === 1'b1)
		begin
			check_outputs();
		end
		// an operation seen during reset gives no result
		valid_prev = op_valid & rst_n;
	end

	initial
	begin
		rst_n <= 1'b0;
		// an operation held during reset must not reach the outputs
		op_valid <= 1'b1;
		a <= '0;
		b <= '0;
		oper <= op_inv;
		lane_size <= sz_8;
		signedness <= 1'b0;
		load_trace();
		if (t_exp.size() == 0)
		begin
			$display("no operations could be read from the trace file");
			$display("Checks failed");
			$finish;
		end
		else
		begin
			run_cycles = reset_cycles + tail_cycles + 2;
			for (int i = 0; i < t_exp.size(); i++)
			begin
				run_cycles += 1 + gap_before(i);
			end
			trace_loaded = 1'b1;
			repeat (reset_cycles) @(posedge clk);
			rst_n <= 1'b1;
			op_valid <= 1'b0;
			for (int i = 0; i < t_exp.size(); i++)
			begin
				idle_cycles(gap_before(i));
				issue_op(i);
			end
			idle_cycles(tail_cycles);
			while (pending.size() != 0)
			begin
				@(posedge clk);
			end
			idle_cycles(2);
			$display("tests %0d  passed %0d  errors %0d", n_tests, passed, errors);
			if (errors == 0 && passed == t_exp.size())
			begin
				$display("All checks passed");
			end
			else
			begin
				$display("Checks failed");
			end
			$finish;
		end
	end

	// watchdog sized from the trace length
	initial
	begin
		wait (trace_loaded);
		#((run_cycles + 20) * clk_period);
		$display("timeout: not all results arrived within %0d cycles", run_cycles + 20);
		$display("Checks failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== testbench/simd_alu_checker.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "simd_alu_consts.svh"

module simd_alu_checker
	import simd_alu_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input logic op_valid,
	input alu_op_e oper,
	input lane_size_e lane_size,
	input logic [`SIMD_DATA_WIDTH-1:0] result,
	input logic result_valid
);

	logic [`SIMD_DATA_WIDTH-1:0] upper_mask;
	logic slt_issued;

	// every bit of an element except bit 0
	always_comb
	begin
		case (lane_size)
		sz_8:
		begin
			upper_mask = ~64'h0101010101010101;
		end
		sz_16:
		begin
			upper_mask = ~64'h0001000100010001;
		end
		sz_32:
		begin
			upper_mask = ~64'h0000000100000001;
		end
		default:
		begin
			upper_mask = ~64'h0000000000000001;
		end
		endcase
	end

	assign slt_issued = rst_n && op_valid && (oper == op_slt);

	// synchronous reset clears the strobe on the next edge
	reset_clears_valid: assert property (@(posedge clk) !rst_n |=> !result_valid)
		else $error("result_valid high in the cycle after reset");

	valid_follows_op: assert property (@(posedge clk)
		$past(rst_n) |-> (result_valid == $past(op_valid)))
		else $error("result_valid does not follow op_valid by one cycle");

	// compare results live in bit 0 of each element
	compare_format: assert property (@(posedge clk)
		$past(slt_issued) |-> ((result & $past(upper_mask)) == '0))
		else $error("set-less-than result has bits set above bit 0 of an element");

endmodule

bind simd_alu simd_alu_checker i_simd_alu_checker (
	.clk(clk),
	.rst_n(rst_n),
	.op_valid(op_valid),
	.oper(oper),
	.lane_size(lane_size),
	.result(result),
	.result_valid(result_valid)
);

`default_nettype wire

// ==== verilog/simd_alu.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "simd_alu_consts.svh"

module simd_alu
	import simd_alu_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input logic op_valid,
	input logic [`SIMD_DATA_WIDTH-1:0] a,
	input logic [`SIMD_DATA_WIDTH-1:0] b,
	input alu_op_e oper,
	input lane_size_e lane_size,
	input logic signedness,
	output logic [`SIMD_DATA_WIDTH-1:0] result,
	output logic result_valid
);

	logic [`SIMD_DATA_WIDTH-1:0] lane_data;
	logic [`SIMD_DATA_WIDTH-1:0] compare_result;
	logic [`SIMD_DATA_WIDTH-1:0] shl_data;
	logic [`SIMD_DATA_WIDTH-1:0] shr_data;

	// add, sub, compare and bitwise ops
	lane_array i_lane_array (
		.a(a),
		.b(b),
		.oper(oper),
		.lane_size(lane_size),
		.signedness(signedness),
		.lane_data(lane_data),
		.compare_result(compare_result)
	);

	lane_shifter i_lane_shifter (
		.a(a),
		.b(b),
		.lane_size(lane_size),
		.signedness(signedness),
		.shl_data(shl_data),
		.shr_data(shr_data)
	);

	// the only registers in the design
	result_stage i_result_stage (
		.clk(clk),
		.rst_n(rst_n),
		.op_valid(op_valid),
		.oper(oper),
		.lane_size(lane_size),
		.a(a),
		.lane_data(lane_data),
		.compare_result(compare_result),
		.shl_data(shl_data),
		.shr_data(shr_data),
		.result(result),
		.result_valid(result_valid)
	);

endmodule

`default_nettype wire

// ==== verilog/result_stage.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "simd_alu_consts.svh"

module result_stage
	import simd_alu_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input logic op_valid,
	input alu_op_e oper,
	input lane_size_e lane_size,
	input logic [`SIMD_DATA_WIDTH-1:0] a,
	input logic [`SIMD_DATA_WIDTH-1:0] lane_data,
	input logic [`SIMD_DATA_WIDTH-1:0] compare_result,
	input logic [`SIMD_DATA_WIDTH-1:0] shl_data,
	input logic [`SIMD_DATA_WIDTH-1:0] shr_data,
	output logic [`SIMD_DATA_WIDTH-1:0] result,
	output logic result_valid
);

	logic [`SIMD_DATA_WIDTH-1:0] not_by_size [4];
	logic [`SIMD_DATA_WIDTH-1:0] not_data;
	logic [`SIMD_DATA_WIDTH-1:0] next_result;

	// logical not, 1 in bit 0 of each element of a that is zero
	for (genvar s = 0; s <= int'(sz_64); s++)
	begin : g_not_size
		localparam int elem_width = `SIMD_LANE_WIDTH << s;

		for (genvar e = 0; e < `SIMD_DATA_WIDTH / elem_width; e++)
		begin : g_elem
			assign not_by_size[s][e * elem_width +: elem_width] =
				{{(elem_width - 1){1'b0}}, ~|a[e * elem_width +: elem_width]};
		end
	end

	assign not_data = not_by_size[lane_size];

	always_comb
	begin
		case (oper)
		op_add, op_sub, op_and, op_orr, op_xor, op_inv:
		begin
			next_result = lane_data;
		end
		op_slt:
		begin
			next_result = compare_result;
		end
		op_shl:
		begin
			next_result = shl_data;
		end
		op_shr:
		begin
			next_result = shr_data;
		end
		op_not:
		begin
			next_result = not_data;
		end
		default:
		begin
			next_result = '0;
		end
		endcase
	end

	// result holds between operations
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			result <= '0;
			result_valid <= 1'b0;
		end
		else
		begin
			result_valid <= op_valid;
			if (op_valid)
			begin
				result <= next_result;
			end
		end
	end

endmodule

`default_nettype wire

// ==== verilog/lane_shifter.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "simd_alu_consts.svh"

module lane_shifter
	import simd_alu_pkg::*;
(
	input logic [`SIMD_DATA_WIDTH-1:0] a,
	input logic [`SIMD_DATA_WIDTH-1:0] b,
	input lane_size_e lane_size,
	input logic signedness,
	output logic [`SIMD_DATA_WIDTH-1:0] shl_data,
	output logic [`SIMD_DATA_WIDTH-1:0] shr_data
);

	// one full-width result per element size
	logic [`SIMD_DATA_WIDTH-1:0] shl_by_size [4];
	logic [`SIMD_DATA_WIDTH-1:0] shr_by_size [4];

	for (genvar s = 0; s <= int'(sz_64); s++)
	begin : g_size
		localparam int elem_width = `SIMD_LANE_WIDTH << s;
		localparam int elem_count = `SIMD_DATA_WIDTH / elem_width;
		localparam int amt_bits = $clog2(elem_width);

		for (genvar e = 0; e < elem_count; e++)
		begin : g_elem
			logic [elem_width-1:0] value;
			logic [elem_width-1:0] amount;
			logic [amt_bits-1:0] amt;
			logic in_range;
			logic fill;
			logic [elem_width-1:0] lsr_val;
			logic [elem_width-1:0] asr_val;

			assign value = a[e * elem_width +: elem_width];
			assign amount = b[e * elem_width +: elem_width];
			assign amt = amount[amt_bits-1:0];

			// any bit above the low log2(W) bits means W or more
			assign in_range = ~|amount[elem_width-1:amt_bits];
			assign fill = signedness & value[elem_width-1];

			assign lsr_val = value >> amt;
			// kept apart so the shift stays signed
			assign asr_val = $signed(value) >>> amt;

			assign shl_by_size[s][e * elem_width +: elem_width] =
				in_range ? (value << amt) : '0;
			assign shr_by_size[s][e * elem_width +: elem_width] =
				in_range ? (signedness ? asr_val : lsr_val)
				: {elem_width{fill}};
		end
	end

	always_comb
	begin
		shl_data = shl_by_size[lane_size];
		shr_data = shr_by_size[lane_size];
	end

endmodule

`default_nettype wire

// ==== verilog/lane_array.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "simd_alu_consts.svh"

module lane_array
	import simd_alu_pkg::*;
(
	input logic [`SIMD_DATA_WIDTH-1:0] a,
	input logic [`SIMD_DATA_WIDTH-1:0] b,
	input alu_op_e oper,
	input lane_size_e lane_size,
	input logic signedness,
	output logic [`SIMD_DATA_WIDTH-1:0] lane_data,
	output logic [`SIMD_DATA_WIDTH-1:0] compare_result
);

	logic [`SIMD_LANE_COUNT-1:0] carry_in;
	logic [`SIMD_LANE_COUNT-1:0] carry_out;
	logic [`SIMD_LANE_COUNT-1:0] less_signed;
	logic [`SIMD_LANE_COUNT-1:0] less_bit;

	// lane 0 always starts an element, so its chain input is a don't care
	assign carry_in = {carry_out[`SIMD_LANE_COUNT-2:0], 1'b0};

	for (genvar i = 0; i < `SIMD_LANE_COUNT; i++)
	begin : g_lane
		alu_lane #(
			.LANE_INDEX(i)
		) i_alu_lane (
			.a(a[i * `SIMD_LANE_WIDTH +: `SIMD_LANE_WIDTH]),
			.b(b[i * `SIMD_LANE_WIDTH +: `SIMD_LANE_WIDTH]),
			.carry_in(carry_in[i]),
			.oper(oper),
			.lane_size(lane_size),
			.data(lane_data[i * `SIMD_LANE_WIDTH +: `SIMD_LANE_WIDTH]),
			.carry_out(carry_out[i]),
			.less_signed(less_signed[i])
		);
	end

	// no carry out of a + ~b + 1 means a < b unsigned
	assign less_bit = signedness ? less_signed : ~carry_out;

	// only the top lane of each element holds the full compare
	always_comb
	begin
		compare_result = '0;
		case (lane_size)
		sz_8:
		begin
			for (int k = 0; k < `SIMD_LANE_COUNT; k++)
			begin
				compare_result[k * `SIMD_LANE_WIDTH] = less_bit[k];
			end
		end
		sz_16:
		begin
			for (int k = 0; k < `SIMD_LANE_COUNT / 2; k++)
			begin
				compare_result[k * 2 * `SIMD_LANE_WIDTH] = less_bit[2 * k + 1];
			end
		end
		sz_32:
		begin
			for (int k = 0; k < `SIMD_LANE_COUNT / 4; k++)
			begin
				compare_result[k * 4 * `SIMD_LANE_WIDTH] = less_bit[4 * k + 3];
			end
		end
		default:
		begin
			compare_result[0] = less_bit[`SIMD_LANE_COUNT-1];
		end
		endcase
	end

endmodule

`default_nettype wire

// ==== verilog/alu_lane.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "simd_alu_consts.svh"

module alu_lane
	import simd_alu_pkg::*;
#(
	parameter int LANE_INDEX = 0
)
(
	input logic [`SIMD_LANE_WIDTH-1:0] a,
	input logic [`SIMD_LANE_WIDTH-1:0] b,
	input logic carry_in,
	input alu_op_e oper,
	input lane_size_e lane_size,
	output logic [`SIMD_LANE_WIDTH-1:0] data,
	output logic carry_out,
	output logic less_signed
);

	localparam logic [`SIMD_LANE_INDEX_WIDTH-1:0] lane_idx =
		LANE_INDEX[`SIMD_LANE_INDEX_WIDTH-1:0];

	logic first_lane;
	logic is_subtract;
	logic actual_carry;
	logic [`SIMD_LANE_WIDTH-1:0] b_eff;
	logic [`SIMD_LANE_WIDTH:0] sum;

	// lowest lane of an element starts its own chain
	always_comb
	begin
		case (lane_size)
		sz_8:
		begin
			first_lane = 1'b1;
		end
		sz_16:
		begin
			first_lane = (lane_idx[0] == 1'b0);
		end
		sz_32:
		begin
			first_lane = (lane_idx[1:0] == 2'b00);
		end
		default:
		begin
			first_lane = (lane_idx == '0);
		end
		endcase
	end

	assign is_subtract = (oper == op_sub) || (oper == op_slt);

	// a - b is done as a + ~b + 1
	assign actual_carry = first_lane ? is_subtract : carry_in;
	assign b_eff = is_subtract ? ~b : b;
	assign sum = {1'b0, a} + {1'b0, b_eff}
		+ {{`SIMD_LANE_WIDTH{1'b0}}, actual_carry};

	always_comb
	begin
		data = '0;
		carry_out = 1'b0;
		case (oper)
		op_add, op_sub, op_slt:
		begin
			data = sum[`SIMD_LANE_WIDTH-1:0];
			carry_out = sum[`SIMD_LANE_WIDTH];
		end
		op_and:
		begin
			data = a & b;
		end
		op_orr:
		begin
			data = a | b;
		end
		op_xor:
		begin
			data = a ^ b;
		end
		op_inv:
		begin
			data = ~a;
		end
		default:
		begin
			data = '0;
		end
		endcase
	end

	// differing signs decide directly, otherwise the sign of the difference
	assign less_signed = (a[`SIMD_LANE_WIDTH-1] ^ b[`SIMD_LANE_WIDTH-1])
		? a[`SIMD_LANE_WIDTH-1] : sum[`SIMD_LANE_WIDTH-1];

endmodule

`default_nettype wire

// ==== verilog/simd_alu_pkg.sv ====
`default_nettype none

package simd_alu_pkg;

	// opcode encoding, any code not listed gives a zero result
	typedef enum logic [3:0]
	{
		op_add = 4'd0,
		op_sub = 4'd1,
		op_slt = 4'd2,
		op_and = 4'd3,
		op_orr = 4'd4,
		op_xor = 4'd5,
		op_shl = 4'd6,
		op_shr = 4'd7,
		op_inv = 4'd8,
		op_not = 4'd9
	} alu_op_e;

	// element size the 64-bit operands are split into
	typedef enum logic [1:0]
	{
		sz_8 = 2'd0,
		sz_16 = 2'd1,
		sz_32 = 2'd2,
		sz_64 = 2'd3
	} lane_size_e;

endpackage

`default_nettype wire

// ==== verilog/simd_alu_consts.svh ====
`ifndef SIMD_ALU_CONSTS_SVH
`define SIMD_ALU_CONSTS_SVH

// operand and result width
`define SIMD_DATA_WIDTH 64

// one lane is a byte
`define SIMD_LANE_WIDTH 8

// lanes across the datapath
`define SIMD_LANE_COUNT 8

// bits needed to number a lane
`define SIMD_LANE_INDEX_WIDTH 3

`endif
